/* build.f */
design/noc_pkg.sv
design/settings_wb_slave.sv
design/setting_reg.sv
design/stream_narrow.sv
design/stream_widen.sv
design/noc_block_skeleton.sv
testbench/noc_block_skeleton_chk.sv
testbench/tb_noc_block_skeleton.sv

/* design/noc_block_skeleton.sv */
//////////////////////////////////////////////////
// NoC block skeleton: settings slave, two test
// registers, readback mux and stream loopback
//////////////////////////////////////////////////

`timescale 1ns/1ps

module noc_block_skeleton #(
  parameter logic [63:0] NOC_ID         = 64'h1234_0000_0000_0000,
  parameter logic [31:0] TEST_REG_RESET = 32'd0
) (
  input  logic                           ce_clk,
  input  logic                           i_rst_n,
  // Wishbone configuration port
  input  logic                           i_wb_cyc,
  input  logic                           i_wb_stb,
  input  logic                           i_wb_we,
  input  logic [noc_pkg::SR_ADDR_W-1:0]  i_wb_adr,
  input  logic [noc_pkg::SR_DATA_W-1:0]  i_wb_dat,
  input  logic [noc_pkg::SR_DATA_W/8-1:0] i_wb_sel,
  output logic                           o_wb_ack,
  output logic [noc_pkg::SR_DATA_W-1:0]  o_wb_dat,
  // Fabric input stream
  input  logic [noc_pkg::NOC_WORD_W-1:0] i_in_tdata,
  input  logic                           i_in_tlast,
  input  logic                           i_in_tvalid,
  output logic                           o_in_tready,
  // Fabric output stream
  output logic [noc_pkg::NOC_WORD_W-1:0] o_out_tdata,
  output logic                           o_out_tlast,
  output logic                           o_out_tvalid,
  input  logic                           i_out_tready
);

  //////////////////////////////////////////////////
  // Settings and readback
  //////////////////////////////////////////////////
  logic                           set_stb;
  logic [noc_pkg::SR_ADDR_W-1:0]  set_addr;
  logic [noc_pkg::SR_DATA_W-1:0]  set_data;
  noc_pkg::rb_sel_e               rb_addr;
  logic [noc_pkg::NOC_WORD_W-1:0] rb_data;
  logic [31:0]                    test_reg_0;
  logic [31:0]                    test_reg_1;

  settings_wb_slave settings_wb_slave_i (
    .ce_clk    (ce_clk),
    .i_rst_n   (i_rst_n),
    .i_wb_cyc  (i_wb_cyc),
    .i_wb_stb  (i_wb_stb),
    .i_wb_we   (i_wb_we),
    .i_wb_adr  (i_wb_adr),
    .i_wb_dat  (i_wb_dat),
    .i_wb_sel  (i_wb_sel),
    .o_wb_ack  (o_wb_ack),
    .o_wb_dat  (o_wb_dat),
    .o_set_stb (set_stb),
    .o_set_addr(set_addr),
    .o_set_data(set_data),
    .o_rb_addr (rb_addr),
    .i_rb_data (rb_data)
  );

  setting_reg #(
    .MY_ADDR  (noc_pkg::SR_TEST_REG_0),
    .WIDTH    (32),
    .RESET_VAL(TEST_REG_RESET)
  ) sr_test_reg_0 (
    .ce_clk   (ce_clk),
    .i_rst_n  (i_rst_n),
    .i_strobe (set_stb),
    .i_addr   (set_addr),
    .i_data   (set_data),
    .o_value  (test_reg_0),
    .o_changed()
  );

  // Second register decodes its own address
  setting_reg #(
    .MY_ADDR  (noc_pkg::SR_TEST_REG_1),
    .WIDTH    (32),
    .RESET_VAL(TEST_REG_RESET)
  ) sr_test_reg_1 (
    .ce_clk   (ce_clk),
    .i_rst_n  (i_rst_n),
    .i_strobe (set_stb),
    .i_addr   (set_addr),
    .i_data   (set_data),
    .o_value  (test_reg_1),
    .o_changed()
  );

  // Readback mux
  always_comb begin
    case (rb_addr)
      noc_pkg::RB_TEST_REG_0: rb_data = {32'd0, test_reg_0};
      noc_pkg::RB_TEST_REG_1: rb_data = {32'd0, test_reg_1};
      noc_pkg::RB_NOC_ID:     rb_data = NOC_ID;
      default:                rb_data = noc_pkg::RB_BAD_ADDR;
    endcase
  end

  //////////////////////////////////////////////////
  // Stream path
  //////////////////////////////////////////////////
  logic [noc_pkg::SAMP_W-1:0] samp_in_tdata;
  logic                       samp_in_tlast;
  logic                       samp_in_tvalid;
  logic                       samp_in_tready;
  logic [noc_pkg::SAMP_W-1:0] samp_out_tdata;
  logic                       samp_out_tlast;
  logic                       samp_out_tvalid;
  logic                       samp_out_tready;

  stream_narrow stream_narrow_i (
    .ce_clk  (ce_clk),
    .i_rst_n (i_rst_n),
    .i_tdata (i_in_tdata),
    .i_tlast (i_in_tlast),
    .i_tvalid(i_in_tvalid),
    .o_tready(o_in_tready),
    .o_tdata (samp_in_tdata),
    .o_tlast (samp_in_tlast),
    .o_tvalid(samp_in_tvalid),
    .i_tready(samp_in_tready)
  );

  // User loopback
  assign samp_out_tdata  = samp_in_tdata;
  assign samp_out_tlast  = samp_in_tlast;
  assign samp_out_tvalid = samp_in_tvalid;
  assign samp_in_tready  = samp_out_tready;

  stream_widen stream_widen_i (
    .ce_clk  (ce_clk),
    .i_rst_n (i_rst_n),
    .i_tdata (samp_out_tdata),
    .i_tlast (samp_out_tlast),
    .i_tvalid(samp_out_tvalid),
    .o_tready(samp_out_tready),
    .o_tdata (o_out_tdata),
    .o_tlast (o_out_tlast),
    .o_tvalid(o_out_tvalid),
    .i_tready(i_out_tready)
  );

endmodule

/* design/noc_pkg.sv */
//////////////////////////////////////////////////
// Widths, settings addresses, readback selectors
// and Wishbone slave states for the NoC block
//////////////////////////////////////////////////

package noc_pkg;

  // Fabric and user side widths
  localparam int NOC_WORD_W = 64;
  localparam int SAMP_W     = 32;

  // Settings bus widths
  localparam int SR_ADDR_W  = 8;
  localparam int SR_DATA_W  = 32;

  //////////////////////////////////////////////////
  // Settings addresses
  //////////////////////////////////////////////////
  localparam logic [SR_ADDR_W-1:0] SR_USER_REG_BASE = 8'd128;
  localparam logic [SR_ADDR_W-1:0] SR_TEST_REG_0    = SR_USER_REG_BASE;
  localparam logic [SR_ADDR_W-1:0] SR_TEST_REG_1    = SR_USER_REG_BASE + 8'd1;

  //////////////////////////////////////////////////
  // Readback selectors
  //////////////////////////////////////////////////
  // Selector is the Wishbone address without bit 0
  typedef enum logic [SR_ADDR_W-2:0] {
    RB_TEST_REG_0 = 7'd0,
    RB_TEST_REG_1 = 7'd1,
    RB_NOC_ID     = 7'd127
  } rb_sel_e;

  // Returned for any selector nobody decodes
  localparam logic [NOC_WORD_W-1:0] RB_BAD_ADDR = 64'h0BAD_C0DE_0BAD_C0DE;

  // Wishbone slave FSM
  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_e;

endpackage

/* design/setting_reg.sv */
//////////////////////////////////////////////////
// Addressed settings register with change pulse
//////////////////////////////////////////////////

`timescale 1ns/1ps

module setting_reg #(
  parameter logic [noc_pkg::SR_ADDR_W-1:0] MY_ADDR   = '0,
  parameter int                            WIDTH     = 32,
  parameter logic [WIDTH-1:0]              RESET_VAL = '0
) (
  input  logic                          ce_clk,
  input  logic                          i_rst_n,
  input  logic                          i_strobe,
  input  logic [noc_pkg::SR_ADDR_W-1:0] i_addr,
  input  logic [noc_pkg::SR_DATA_W-1:0] i_data,
  output logic [WIDTH-1:0]              o_value,
  output logic                          o_changed
);

  logic hit;

  assign hit = i_strobe && (i_addr == MY_ADDR);

  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      o_value   <= RESET_VAL;
      o_changed <= 1'b0;
    end else begin
      // Pulse for one cycle per load
      o_changed <= hit;
      if (hit) begin
        o_value <= i_data[WIDTH-1:0];
      end
    end
  end

endmodule

/* design/settings_wb_slave.sv */
//////////////////////////////////////////////////
// Wishbone classic slave for settings writes and
// readback reads, one wait cycle per access
//////////////////////////////////////////////////

`timescale 1ns/1ps

module settings_wb_slave (
  input  logic                                ce_clk,
  input  logic                                i_rst_n,
  // Wishbone classic slave
  input  logic                                i_wb_cyc,
  input  logic                                i_wb_stb,
  input  logic                                i_wb_we,
  input  logic [noc_pkg::SR_ADDR_W-1:0]       i_wb_adr,
  input  logic [noc_pkg::SR_DATA_W-1:0]       i_wb_dat,
  input  logic [noc_pkg::SR_DATA_W/8-1:0]     i_wb_sel,
  output logic                                o_wb_ack,
  output logic [noc_pkg::SR_DATA_W-1:0]       o_wb_dat,
  // Settings bus
  output logic                                o_set_stb,
  output logic [noc_pkg::SR_ADDR_W-1:0]       o_set_addr,
  output logic [noc_pkg::SR_DATA_W-1:0]       o_set_data,
  // Readback lookup
  output noc_pkg::rb_sel_e                    o_rb_addr,
  input  logic [noc_pkg::NOC_WORD_W-1:0]      i_rb_data
);

  noc_pkg::wb_state_e              state_q;
  logic                            req;
  logic                            we_q;
  logic [noc_pkg::SR_ADDR_W-1:0]   adr_q;
  logic [noc_pkg::SR_DATA_W-1:0]   dat_q;

  // New access seen only from idle
  assign req = i_wb_cyc && i_wb_stb && (state_q == noc_pkg::WB_IDLE);

  //////////////////////////////////////////////////
  // Access FSM
  //////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      state_q <= noc_pkg::WB_IDLE;
    end else begin
      case (state_q)
        noc_pkg::WB_IDLE: begin
          if (req) begin
            state_q <= noc_pkg::WB_ACK;
          end
        end
        noc_pkg::WB_ACK: begin
          // Master drops stb after ack
          state_q <= noc_pkg::WB_IDLE;
        end
        default: begin
          state_q <= noc_pkg::WB_IDLE;
        end
      endcase
    end
  end

  // Request capture; byte selects do not matter
  // since every setting is a full word (i_wb_sel unused)
  always_ff @(posedge ce_clk) begin
    if (req) begin
      we_q  <= i_wb_we;
      adr_q <= i_wb_adr;
      dat_q <= i_wb_dat;
    end
  end

  assign o_wb_ack = (state_q == noc_pkg::WB_ACK);

  // Write strobe lands in the ack cycle
  assign o_set_stb  = o_wb_ack && we_q;
  assign o_set_addr = adr_q;
  assign o_set_data = dat_q;

  //////////////////////////////////////////////////
  // Readback
  //////////////////////////////////////////////////
  assign o_rb_addr = noc_pkg::rb_sel_e'(adr_q[noc_pkg::SR_ADDR_W-1:1]);

  // Bit 0 picks the half of the 64-bit readback word
  assign o_wb_dat = adr_q[0] ?
                    i_rb_data[noc_pkg::NOC_WORD_W-1:noc_pkg::SR_DATA_W] :
                    i_rb_data[noc_pkg::SR_DATA_W-1:0];

endmodule

/* design/stream_narrow.sv */
//////////////////////////////////////////////////
// 64-bit to 32-bit stream narrower, high half
// first, last on the low half only
//////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_narrow (
  input  logic                           ce_clk,
  input  logic                           i_rst_n,
  // Wide side
  input  logic [noc_pkg::NOC_WORD_W-1:0] i_tdata,
  input  logic                           i_tlast,
  input  logic                           i_tvalid,
  output logic                           o_tready,
  // Narrow side
  output logic [noc_pkg::SAMP_W-1:0]     o_tdata,
  output logic                           o_tlast,
  output logic                           o_tvalid,
  input  logic                           i_tready
);

  logic [noc_pkg::NOC_WORD_W-1:0] word_q;
  logic                           last_q;
  logic                           full_q;
  // 0 while the high half is pending, 1 for the low half
  logic                           half_q;
  logic                           accept;

  // Take a new word when empty or when the low half leaves now
  assign o_tready = !full_q || (half_q && i_tready);
  assign accept   = i_tvalid && o_tready;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      full_q <= 1'b0;
      half_q <= 1'b0;
    end else if (accept) begin
      full_q <= 1'b1;
      half_q <= 1'b0;
    end else if (full_q && i_tready) begin
      if (half_q) begin
        full_q <= 1'b0;
        half_q <= 1'b0;
      end else begin
        half_q <= 1'b1;
      end
    end
  end

  // Word holding register
  always_ff @(posedge ce_clk) begin
    if (accept) begin
      word_q <= i_tdata;
      last_q <= i_tlast;
    end
  end

  //////////////////////////////////////////////////
  // Output
  //////////////////////////////////////////////////
  assign o_tvalid = full_q;
  assign o_tdata  = half_q ? word_q[noc_pkg::SAMP_W-1:0] :
                             word_q[noc_pkg::NOC_WORD_W-1:noc_pkg::SAMP_W];
  assign o_tlast  = half_q && last_q;

endmodule

/* design/stream_widen.sv */
//////////////////////////////////////////////////
// 32-bit to 64-bit stream widener, first sample
// in the high half, registered output word
//////////////////////////////////////////////////

`timescale 1ns/1ps

module stream_widen (
  input  logic                           ce_clk,
  input  logic                           i_rst_n,
  // Narrow side
  input  logic [noc_pkg::SAMP_W-1:0]     i_tdata,
  input  logic                           i_tlast,
  input  logic                           i_tvalid,
  output logic                           o_tready,
  // Wide side
  output logic [noc_pkg::NOC_WORD_W-1:0] o_tdata,
  output logic                           o_tlast,
  output logic                           o_tvalid,
  input  logic                           i_tready
);

  logic [noc_pkg::SAMP_W-1:0] first_q;
  logic                       have_first_q;
  logic                       xfer_in;
  logic                       complete;

  // Stall only while a finished word is stuck at the output
  assign o_tready = !o_tvalid || i_tready;
  assign xfer_in  = i_tvalid && o_tready;
  assign complete = xfer_in && have_first_q;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (!i_rst_n) begin
      have_first_q <= 1'b0;
      o_tvalid     <= 1'b0;
    end else begin
      if (xfer_in) begin
        have_first_q <= !have_first_q;
      end
      if (complete) begin
        o_tvalid <= 1'b1;
      end else if (i_tready) begin
        o_tvalid <= 1'b0;
      end
    end
  end

  // First sample; its last flag carries no meaning
  always_ff @(posedge ce_clk) begin
    if (xfer_in && !have_first_q) begin
      first_q <= i_tdata;
    end
  end

  //////////////////////////////////////////////////
  // Output word register
  //////////////////////////////////////////////////
  always_ff @(posedge ce_clk) begin
    if (complete) begin
      o_tdata <= {first_q, i_tdata};
      o_tlast <= i_tlast;
    end
  end

endmodule

/* testbench/noc_block_skeleton_chk.sv */
//////////////////////////////////////////////////
// Bound protocol assertions on the NoC block ports
//////////////////////////////////////////////////

`timescale 1ns/1ps

module noc_block_skeleton_chk (
  input logic                           ce_clk,
  input logic                           i_rst_n,
  input logic                           i_wb_cyc,
  input logic                           i_wb_stb,
  input logic                           o_wb_ack,
  input logic [noc_pkg::NOC_WORD_W-1:0] o_out_tdata,
  input logic                           o_out_tlast,
  input logic                           o_out_tvalid,
  input logic                           i_out_tready
);

  // Read by the testbench to end the run
  int err_count = 0;

  // Request seen in idle is acknowledged on the next edge
  ack_after_request: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (i_wb_cyc && i_wb_stb && !o_wb_ack) |=> o_wb_ack)
    else begin
      $error("Wishbone ack did not follow the request by one cycle");
      err_count++;
    end

  ack_one_cycle: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    o_wb_ack |=> !o_wb_ack)
    else begin
      $error("Wishbone ack stayed high for more than one cycle");
      err_count++;
    end

  // Stalled output word must not move
  out_stable_stalled: assert property (@(posedge ce_clk) disable iff (!i_rst_n)
    (o_out_tvalid && !i_out_tready) |=>
      (o_out_tvalid && $stable(o_out_tdata) && $stable(o_out_tlast)))
    else begin
      $error("Output stream changed while stalled");
      err_count++;
    end

  // Second reset cycle onwards
  no_valid_in_reset: assert property (@(posedge ce_clk)
    (!i_rst_n && $past(!i_rst_n)) |-> (!o_out_tvalid && !o_wb_ack))
    else begin
      $error("Valid or ack high during reset");
      err_count++;
    end

endmodule

/* testbench/tb_noc_block_skeleton.sv */
//////////////////////////////////////////////////
// Testbench for the NoC block with settings readback,
// stream loopback under stalls and Wishbone timing
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_noc_block_skeleton;

  localparam logic [63:0] NOC_ID  = 64'h1234_0000_0000_0000;
  // About four times the expected test length
  localparam int          TIMEOUT = 4000;

  logic        ce_clk;
  logic        i_rst_n;
  logic        i_wb_cyc;
  logic        i_wb_stb;
  logic        i_wb_we;
  logic [7:0]  i_wb_adr;
  logic [31:0] i_wb_dat;
  logic [3:0]  i_wb_sel;
  logic        o_wb_ack;
  logic [31:0] o_wb_dat;
  logic [63:0] i_in_tdata;
  logic        i_in_tlast;
  logic        i_in_tvalid;
  logic        o_in_tready;
  logic [63:0] o_out_tdata;
  logic        o_out_tlast;
  logic        o_out_tvalid;
  logic        i_out_tready;

  integer      seed = 32'h13c9_0ad9;
  int          cycle_count = 0;
  int          rx_count = 0;
  logic        in_fired = 1'b0;
  logic [64:0] sent_q[$];
  logic [64:0] expected_word;
  logic [31:0] val_0;
  logic [31:0] val_1;
  logic [31:0] val_2;

  noc_block_skeleton #(
    .NOC_ID        (NOC_ID),
    .TEST_REG_RESET(32'd0)
  ) dut_i (.*);

  bind noc_block_skeleton noc_block_skeleton_chk chk_i (.*);

  initial begin
    ce_clk = 1'b0;
    forever #20 ce_clk = ~ce_clk;
  end

  task automatic end_with_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      end_with_failure();
    end
  endtask

  //////////////////////////////////////////////////
  // Wishbone master
  //////////////////////////////////////////////////
  task automatic wb_access(input logic we, input logic [7:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int waited;
    @(negedge ce_clk);
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    waited   = 0;
    do begin
      @(negedge ce_clk);
      waited++;
    end while (!o_wb_ack);
    check_value("wb ack latency", 64'd1, waited);
    rdat     = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    @(negedge ce_clk);
    check_value("wb ack width", 64'd0, o_wb_ack);
  endtask

  task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
    logic [31:0] rd_dummy;
    wb_access(1'b1, adr, data, rd_dummy);
  endtask

  task automatic wb_read_expect(input string name, input logic [7:0] adr,
                                input logic [31:0] expected);
    logic [31:0] rd;
    wb_access(1'b0, adr, 32'd0, rd);
    check_value(name, expected, rd);
  endtask

  //////////////////////////////////////////////////
  // Stream driver and scoreboard
  //////////////////////////////////////////////////
  // Packet ends every 5 words
  // Runs until every sent word is back
  task automatic run_stream(input int n_words, input bit stalls);
    int          sent;
    logic [63:0] word;
    sent = 0;
    while (sent < n_words || i_in_tvalid || sent_q.size() != 0) begin
      @(negedge ce_clk);
      i_out_tready = stalls ? (($random(seed) & 1) != 0) : 1'b1;
      if (!i_in_tvalid || in_fired) begin
        if (sent < n_words && (!stalls || ($random(seed) & 3) != 0)) begin
          word[63:32] = $random(seed);
          word[31:0]  = $random(seed);
          i_in_tdata  = word;
          i_in_tlast  = (sent % 5 == 4);
          i_in_tvalid = 1'b1;
          sent++;
        end else begin
          i_in_tvalid = 1'b0;
        end
      end
    end
    i_out_tready = 1'b1;
  endtask

  always @(posedge ce_clk) begin
    in_fired = i_rst_n && i_in_tvalid && o_in_tready;
    if (in_fired) begin
      sent_q.push_back({i_in_tlast, i_in_tdata});
    end
    if (i_rst_n && o_out_tvalid && i_out_tready) begin
      if (sent_q.size() == 0) begin
        $display("Output word %h appeared with no input word pending", o_out_tdata);
        end_with_failure();
      end
      expected_word = sent_q.pop_front();
      check_value($sformatf("stream word %0d data", rx_count),
                  expected_word[63:0], o_out_tdata);
      check_value($sformatf("stream word %0d last", rx_count),
                  expected_word[64], o_out_tlast);
      rx_count++;
    end
  end

  // Timeout and bound assertion watch
  always @(posedge ce_clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      end_with_failure();
    end
  end

  always @(negedge ce_clk) begin
    if (dut_i.chk_i.err_count != 0) begin
      $display("A bound protocol assertion failed");
      end_with_failure();
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    i_rst_n      = 1'b0;
    i_wb_cyc     = 1'b0;
    i_wb_stb     = 1'b0;
    i_wb_we      = 1'b0;
    i_wb_adr     = 8'd0;
    i_wb_dat     = 32'd0;
    i_wb_sel     = 4'hf;
    i_in_tdata   = 64'd0;
    i_in_tlast   = 1'b0;
    i_in_tvalid  = 1'b0;
    i_out_tready = 1'b1;
    repeat (8) @(posedge ce_clk);
    @(negedge ce_clk);
    i_rst_n = 1'b1;

    // Reset values and both halves of NOC_ID
    wb_read_expect("reset reg0 low", 8'd0, 32'd0);
    wb_read_expect("reset reg0 high", 8'd1, 32'd0);
    wb_read_expect("reset reg1 low", 8'd2, 32'd0);
    wb_read_expect("reset reg1 high", 8'd3, 32'd0);
    wb_read_expect("noc id low", 8'd254, NOC_ID[31:0]);
    wb_read_expect("noc id high", 8'd255, NOC_ID[63:32]);

    // Test register write and readback
    val_0 = $random(seed);
    val_1 = $random(seed);
    wb_write(8'd128, val_0);
    wb_write(8'd129, val_1);
    wb_read_expect("reg0 low", 8'd0, val_0);
    wb_read_expect("reg0 high", 8'd1, 32'd0);
    wb_read_expect("reg1 low", 8'd2, val_1);
    wb_read_expect("reg1 high", 8'd3, 32'd0);
    wb_write(8'd130, $random(seed));
    wb_read_expect("reg0 after unused write", 8'd0, val_0);
    wb_read_expect("reg1 after unused write", 8'd2, val_1);

    // Undecoded selectors 2 and 50
    wb_read_expect("bad sel 2 low", 8'd4, 32'h0BAD_C0DE);
    wb_read_expect("bad sel 2 high", 8'd5, 32'h0BAD_C0DE);
    wb_read_expect("bad sel 50 low", 8'd100, 32'h0BAD_C0DE);
    wb_read_expect("bad sel 50 high", 8'd101, 32'h0BAD_C0DE);

    run_stream(40, 1'b0);

    // Stalls on both sides plus a settings write mid-stream
    val_2 = $random(seed);
    fork
      run_stream(40, 1'b1);
      begin
        repeat (12) @(negedge ce_clk);
        wb_write(8'd128, val_2);
      end
    join
    wb_read_expect("reg0 written during traffic", 8'd0, val_2);

    if (dut_i.chk_i.err_count != 0) begin
      $display("A bound protocol assertion failed");
      end_with_failure();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule
